// File: verilog/vec_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector subsystem package: sizes, opcodes, unit
// codes and the PE instruction payloads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package vec_pkg;

  // Lanes, plus the load/store unit and the mask unit
  localparam int unsigned NR_LANES = 2;
  localparam int unsigned NR_PES   = NR_LANES + 2;

  // PE index offsets counted after the last lane
  localparam int unsigned OFFSET_LSU  = 0;
  localparam int unsigned OFFSET_MASK = 1;

  // Instruction ids in flight
  localparam int unsigned NR_VINSN = 8;

  localparam int unsigned NR_VREGS = 32;
  localparam int unsigned VL_W     = 6;
  localparam int unsigned ELEN_W   = 32;

  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;

  // Masked instructions read v0
  localparam vreg_t VMASK_REG = vreg_t'(0);

  typedef enum logic [2:0] {
    VADD,
    VXOR,
    VREDSUM,
    VMAND,
    VLE,
    VSE
  } vec_op_e;

  typedef enum logic [1:0] {
    VFU_ALU,
    VFU_MASK,
    VFU_LSU
  } vfu_e;

  // Lane and mask unit payload, keeps the op for reductions
  typedef struct packed {
    vid_t                id;
    vec_op_e             op;
    logic [VL_W-1:0]     vl;
    logic [NR_VINSN-1:0] hazard;
    logic [ELEN_W-1:0]   scalar;
  } lane_insn_t;

  // Load/store payload, the scalar operand is the base address
  typedef struct packed {
    vid_t                id;
    logic [VL_W-1:0]     vl;
    logic [NR_VINSN-1:0] hazard;
    logic [ELEN_W-1:0]   scalar;
  } lsu_insn_t;

endpackage

// File: verilog/vec_free_id.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free id search: lowest clear bit of the running mask
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vec_free_id (
  input  logic [vec_pkg::NR_VINSN-1:0] running_i,
  output vec_pkg::vid_t                id_o,
  output logic                         full_o
);

  import vec_pkg::*;

  // Walk from the top so the lowest free id wins
  always_comb begin
    id_o   = '0;
    full_o = 1'b1;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!running_i[i]) begin
        id_o   = vid_t'(i);
        full_o = 1'b0;
      end
    end
  end

endmodule

// File: verilog/vec_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector sequencer: assigns ids, tracks hazards and
// broadcasts requests to the processing elements
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vec_sequencer (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  // Dispatcher side
  input  logic                                              req_valid_i,
  input  vec_pkg::vec_op_e                                  req_op_i,
  input  vec_pkg::vreg_t                                    req_vs1_i,
  input  logic                                              req_use_vs1_i,
  input  vec_pkg::vreg_t                                    req_vs2_i,
  input  logic                                              req_use_vs2_i,
  input  vec_pkg::vreg_t                                    req_vd_i,
  input  logic                                              req_use_vd_i,
  input  logic                                              req_vm_i,
  input  logic [vec_pkg::VL_W-1:0]                          req_vl_i,
  input  logic [vec_pkg::ELEN_W-1:0]                        req_scalar_i,
  output logic                                              req_ready_o,
  output logic                                              resp_valid_o,
  output logic [vec_pkg::ELEN_W-1:0]                        resp_data_o,
  output logic                                              resp_error_o,
  // Broadcast to the PEs
  output logic                                              pe_valid_o,
  output vec_pkg::vid_t                                     pe_id_o,
  output vec_pkg::vec_op_e                                  pe_op_o,
  output vec_pkg::vfu_e                                     pe_vfu_o,
  output logic [vec_pkg::VL_W-1:0]                          pe_vl_o,
  output logic [vec_pkg::ELEN_W-1:0]                        pe_scalar_o,
  output logic                                              pe_vm_o,
  output logic [vec_pkg::NR_VINSN-1:0]                      pe_hazard_o,
  output logic [vec_pkg::NR_VINSN-1:0]                      running_o,
  input  logic [vec_pkg::NR_PES-1:0]                        pe_ready_i,
  input  logic [vec_pkg::NR_PES-1:0][vec_pkg::NR_VINSN-1:0] pe_done_i,
  // Answers from lane 0 and the load/store unit
  input  logic                                              scalar_valid_i,
  input  logic [vec_pkg::ELEN_W-1:0]                        scalar_data_i,
  input  logic                                              addr_ack_i,
  input  logic                                              addr_error_i
);

  import vec_pkg::*;

  localparam int unsigned LSU_IDX  = NR_LANES + OFFSET_LSU;
  localparam int unsigned MASK_IDX = NR_LANES + OFFSET_MASK;

  typedef enum logic {IDLE, WAIT} state_e;

  // Last instruction reading or writing each register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  state_e                          state_d, state_q;
  logic [NR_PES-1:0][NR_VINSN-1:0] pe_running_d, pe_running_q;
  logic [NR_VINSN-1:0]             store_running_d, store_running_q;
  logic [NR_VINSN-1:0]             running;
  vreg_access_t [NR_VREGS-1:0]     read_list_d, read_list_q;
  vreg_access_t [NR_VREGS-1:0]     write_list_d, write_list_q;
  vid_t                            next_id;
  logic                            ids_full;
  vfu_e                            req_vfu;
  logic                            conflict;
  logic                            can_issue;

  logic                            pe_valid_d;
  vid_t                            pe_id_d;
  vec_op_e                         pe_op_d;
  vfu_e                            pe_vfu_d;
  logic [VL_W-1:0]                 pe_vl_d;
  logic [ELEN_W-1:0]               pe_scalar_d;
  logic                            pe_vm_d;
  logic [NR_VINSN-1:0]             pe_hazard_d;

  function automatic vfu_e op_vfu(vec_op_e op);
    case (op)
      VMAND:    return VFU_MASK;
      VLE, VSE: return VFU_LSU;
      default:  return VFU_ALU;
    endcase
  endfunction

  // An id runs until every PE holding it is done
  always_comb begin
    running = '0;
    for (int p = 0; p < NR_PES; p++) begin
      running |= pe_running_q[p];
    end
  end

  assign running_o = running;

  vec_free_id i_free_id (
    .running_i(running),
    .id_o     (next_id),
    .full_o   (ids_full)
  );

  assign req_vfu = op_vfu(req_op_i);

  // Stores and mask unit work never overlap
  assign conflict = ((req_op_i == VSE) && |pe_running_q[MASK_IDX]) ||
                    (((req_vfu == VFU_MASK) || !req_vm_i) &&
                     |(store_running_q & pe_running_q[LSU_IDX]));

  assign can_issue = &pe_ready_i && !ids_full && !conflict;

  always_comb begin
    state_d         = state_q;
    pe_running_d    = pe_running_q;
    store_running_d = store_running_q & pe_running_q[LSU_IDX];
    read_list_d     = read_list_q;
    write_list_d    = write_list_q;

    // Broadcast payload holds, hazards shrink as ids retire
    pe_valid_d  = 1'b0;
    pe_id_d     = pe_id_o;
    pe_op_d     = pe_op_o;
    pe_vfu_d    = pe_vfu_o;
    pe_vl_d     = pe_vl_o;
    pe_scalar_d = pe_scalar_o;
    pe_vm_d     = pe_vm_o;
    pe_hazard_d = pe_hazard_o & running;

    req_ready_o  = 1'b0;
    resp_valid_o = 1'b0;
    resp_data_o  = '0;
    resp_error_o = 1'b0;

    // Drop list entries whose id has retired
    for (int v = 0; v < NR_VREGS; v++) begin
      read_list_d[v].valid  = read_list_q[v].valid & running[read_list_q[v].vid];
      write_list_d[v].valid = write_list_q[v].valid & running[write_list_q[v].vid];
    end

    for (int p = 0; p < NR_PES; p++) begin
      pe_running_d[p] = pe_running_q[p] & ~pe_done_i[p];
    end

    case (state_q)
      IDLE: begin
        req_ready_o = can_issue;
        if (req_valid_i && can_issue) begin
          // Mark the PEs that will run it
          if (req_vfu == VFU_ALU) begin
            for (int l = 0; l < NR_LANES; l++) begin
              pe_running_d[l][next_id] = 1'b1;
            end
          end else if (req_vfu == VFU_LSU) begin
            pe_running_d[LSU_IDX][next_id] = 1'b1;
          end
          // Masked instructions also go to the mask unit
          if ((req_vfu == VFU_MASK) || !req_vm_i) begin
            pe_running_d[MASK_IDX][next_id] = 1'b1;
          end
          if (req_op_i == VSE) begin
            store_running_d[next_id] = 1'b1;
          end

          pe_valid_d  = 1'b1;
          pe_id_d     = next_id;
          pe_op_d     = req_op_i;
          pe_vfu_d    = req_vfu;
          pe_vl_d     = req_vl_i;
          pe_scalar_d = req_scalar_i;
          pe_vm_d     = req_vm_i;
          pe_hazard_d = '0;

          // RAW on both sources and the mask
          if (req_use_vs1_i && write_list_d[req_vs1_i].valid)
            pe_hazard_d[write_list_d[req_vs1_i].vid] = 1'b1;
          if (req_use_vs2_i && write_list_d[req_vs2_i].valid)
            pe_hazard_d[write_list_d[req_vs2_i].vid] = 1'b1;
          if (!req_vm_i && write_list_d[VMASK_REG].valid)
            pe_hazard_d[write_list_d[VMASK_REG].vid] = 1'b1;
          // WAR and WAW on the destination
          if (req_use_vd_i && read_list_d[req_vd_i].valid)
            pe_hazard_d[read_list_d[req_vd_i].vid] = 1'b1;
          if (req_use_vd_i && write_list_d[req_vd_i].valid)
            pe_hazard_d[write_list_d[req_vd_i].vid] = 1'b1;

          // Record the new accesses after the hazard lookup
          if (req_use_vd_i)
            write_list_d[req_vd_i] = '{vid: next_id, valid: 1'b1};
          if (req_use_vs1_i)
            read_list_d[req_vs1_i] = '{vid: next_id, valid: 1'b1};
          if (req_use_vs2_i)
            read_list_d[req_vs2_i] = '{vid: next_id, valid: 1'b1};
          if (!req_vm_i)
            read_list_d[VMASK_REG] = '{vid: next_id, valid: 1'b1};

          // Loads, stores and reductions owe the dispatcher a response
          if (req_op_i inside {VLE, VSE, VREDSUM}) begin
            state_d = WAIT;
          end
        end
      end

      WAIT: begin
        // Address check from the load/store unit
        if ((pe_op_o inside {VLE, VSE}) && addr_ack_i) begin
          state_d      = IDLE;
          resp_valid_o = 1'b1;
          resp_error_o = addr_error_i;
        end
        // Scalar result from lane 0
        if ((pe_op_o == VREDSUM) && scalar_valid_i) begin
          state_d      = IDLE;
          resp_valid_o = 1'b1;
          resp_data_o  = scalar_data_i;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= IDLE;
      pe_running_q    <= '0;
      store_running_q <= '0;
      read_list_q     <= '0;
      write_list_q    <= '0;
      pe_valid_o      <= 1'b0;
    end else begin
      state_q         <= state_d;
      pe_running_q    <= pe_running_d;
      store_running_q <= store_running_d;
      read_list_q     <= read_list_d;
      write_list_q    <= write_list_d;
      pe_valid_o      <= pe_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    pe_id_o     <= pe_id_d;
    pe_op_o     <= pe_op_d;
    pe_vfu_o    <= pe_vfu_d;
    pe_vl_o     <= pe_vl_d;
    pe_scalar_o <= pe_scalar_d;
    pe_vm_o     <= pe_vm_d;
    pe_hazard_o <= pe_hazard_d;
  end

endmodule

// File: verilog/vec_insn_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry instruction FIFO for one PE
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vec_insn_queue #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  payload_t   mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;

  assign full_o  = (count_q == 2'd2);
  assign empty_o = (count_q == 2'd0);
  // Head is visible without a pop
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= '0;
    end else begin
      if (push_i)
        wr_ptr_q <= ~wr_ptr_q;
      if (pop_i)
        rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + {1'b0, push_i} - {1'b0, pop_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i)
      mem_q[wr_ptr_q] <= data_i;
  end

endmodule

// File: verilog/vec_pe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Processing element: queues, waits on hazards,
// runs for vl+1 cycles and reports done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vec_pe #(
  parameter vec_pkg::vfu_e UNIT = vec_pkg::VFU_ALU
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         pe_valid_i,
  input  vec_pkg::vid_t                pe_id_i,
  input  vec_pkg::vec_op_e             pe_op_i,
  input  vec_pkg::vfu_e                pe_vfu_i,
  input  logic [vec_pkg::VL_W-1:0]     pe_vl_i,
  input  logic [vec_pkg::ELEN_W-1:0]   pe_scalar_i,
  input  logic                         pe_vm_i,
  input  logic [vec_pkg::NR_VINSN-1:0] pe_hazard_i,
  input  logic [vec_pkg::NR_VINSN-1:0] running_i,
  output logic                         ready_o,
  output logic [vec_pkg::NR_VINSN-1:0] done_o,
  output logic                         scalar_valid_o,
  output logic [vec_pkg::ELEN_W-1:0]   scalar_data_o,
  output logic                         addr_ack_o,
  output logic                         addr_error_o
);

  import vec_pkg::*;

  logic                     push, pop, full, empty;
  vid_t                     head_id;
  logic                     head_redsum;
  logic [VL_W-1:0]          head_vl;
  logic [NR_VINSN-1:0]      head_hazard;
  logic [ELEN_W-1:0]        head_scalar;
  // Ids not yet retired since each slot was filled
  logic [1:0][NR_VINSN-1:0] live_q;
  logic                     busy_q;
  logic [VL_W-1:0]          cnt_q;
  vid_t                     cur_id_q;
  logic                     cur_redsum_q;
  logic [VL_W-1:0]          cur_vl_q;
  logic [ELEN_W-1:0]        cur_scalar_q;
  logic [1:0]               ack_q;
  logic [1:0]               err_q;

  // Mask unit also takes every masked instruction
  assign push    = pe_valid_i && ((pe_vfu_i == UNIT) || ((UNIT == VFU_MASK) && !pe_vm_i));
  // A push still on its way in takes the last free slot
  assign ready_o = !full && !(push && !empty);
  // Start the head once all of its hazards have retired
  assign pop     = !empty && !busy_q && ((head_hazard & live_q[0] & running_i) == '0);

  if (UNIT == VFU_LSU) begin : g_lsu_queue
    lsu_insn_t q_in, q_out;
    assign q_in = '{id: pe_id_i, vl: pe_vl_i, hazard: pe_hazard_i, scalar: pe_scalar_i};
    vec_insn_queue #(.payload_t(lsu_insn_t)) i_queue (
      .clk_i(clk_i), .rst_ni(rst_ni), .push_i(push), .data_i(q_in), .full_o(full),
      .pop_i(pop), .data_o(q_out), .empty_o(empty)
    );
    assign head_id     = q_out.id;
    assign head_redsum = 1'b0;
    assign head_vl     = q_out.vl;
    assign head_hazard = q_out.hazard;
    assign head_scalar = q_out.scalar;
  end else begin : g_lane_queue
    lane_insn_t q_in, q_out;
    assign q_in = '{id: pe_id_i, op: pe_op_i, vl: pe_vl_i, hazard: pe_hazard_i,
                    scalar: pe_scalar_i};
    vec_insn_queue #(.payload_t(lane_insn_t)) i_queue (
      .clk_i(clk_i), .rst_ni(rst_ni), .push_i(push), .data_i(q_in), .full_o(full),
      .pop_i(pop), .data_o(q_out), .empty_o(empty)
    );
    assign head_id     = q_out.id;
    // Only lanes produce the reduction result
    assign head_redsum = (q_out.op == VREDSUM) && (UNIT == VFU_ALU);
    assign head_vl     = q_out.vl;
    assign head_hazard = q_out.hazard;
    assign head_scalar = q_out.scalar;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      live_q         <= '0;
      busy_q         <= 1'b0;
      cnt_q          <= '0;
      done_o         <= '0;
      scalar_valid_o <= 1'b0;
      ack_q          <= '0;
    end else begin
      // Slots follow the queue, a retired id stays cleared
      live_q[0] <= (pop ? live_q[1] : live_q[0]) & running_i;
      live_q[1] <= live_q[1] & running_i;
      if (push) begin
        if (empty || (pop && !full))
          live_q[0] <= running_i;
        else
          live_q[1] <= running_i;
      end

      done_o         <= '0;
      scalar_valid_o <= 1'b0;
      if (pop) begin
        busy_q <= 1'b1;
        cnt_q  <= head_vl;
      end else if (busy_q) begin
        if (cnt_q == '0) begin
          busy_q           <= 1'b0;
          done_o[cur_id_q] <= 1'b1;
          scalar_valid_o   <= cur_redsum_q;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end

      // Address acknowledge two cycles after accept
      ack_q <= {ack_q[0], push && (UNIT == VFU_LSU)};
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      cur_id_q     <= head_id;
      cur_redsum_q <= head_redsum;
      cur_vl_q     <= head_vl;
      cur_scalar_q <= head_scalar;
    end
    if (busy_q && (cnt_q == '0))
      scalar_data_o <= cur_scalar_q + ELEN_W'(cur_vl_q);
    err_q <= {err_q[0], |pe_scalar_i[1:0]};
  end

  assign addr_ack_o   = ack_q[1];
  assign addr_error_o = err_q[1];

endmodule

// File: verilog/vec_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector subsystem top: sequencer, lanes, load/store
// unit and mask unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vec_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_valid_i,
  input  vec_pkg::vec_op_e             req_op_i,
  input  vec_pkg::vreg_t               req_vs1_i,
  input  logic                         req_use_vs1_i,
  input  vec_pkg::vreg_t               req_vs2_i,
  input  logic                         req_use_vs2_i,
  input  vec_pkg::vreg_t               req_vd_i,
  input  logic                         req_use_vd_i,
  input  logic                         req_vm_i,
  input  logic [vec_pkg::VL_W-1:0]     req_vl_i,
  input  logic [vec_pkg::ELEN_W-1:0]   req_scalar_i,
  output logic                         req_ready_o,
  output logic                         resp_valid_o,
  output logic [vec_pkg::ELEN_W-1:0]   resp_data_o,
  output logic                         resp_error_o,
  output logic [vec_pkg::NR_VINSN-1:0] done_o
);

  import vec_pkg::*;

  localparam int unsigned LSU_IDX = NR_LANES + OFFSET_LSU;

  logic                            pe_valid;
  vid_t                            pe_id;
  vec_op_e                         pe_op;
  vfu_e                            pe_vfu;
  logic [VL_W-1:0]                 pe_vl;
  logic [ELEN_W-1:0]               pe_scalar;
  logic                            pe_vm;
  logic [NR_VINSN-1:0]             pe_hazard;
  logic [NR_VINSN-1:0]             running;
  logic [NR_PES-1:0]               pe_ready, pe_scalar_valid, pe_addr_ack, pe_addr_error;
  logic [NR_PES-1:0][ELEN_W-1:0]   pe_scalar_data;
  logic [NR_PES-1:0][NR_VINSN-1:0] pe_done;

  vec_sequencer i_sequencer (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .req_valid_i(req_valid_i), .req_op_i(req_op_i),
    .req_vs1_i(req_vs1_i), .req_use_vs1_i(req_use_vs1_i),
    .req_vs2_i(req_vs2_i), .req_use_vs2_i(req_use_vs2_i),
    .req_vd_i(req_vd_i), .req_use_vd_i(req_use_vd_i),
    .req_vm_i(req_vm_i), .req_vl_i(req_vl_i), .req_scalar_i(req_scalar_i),
    .req_ready_o(req_ready_o), .resp_valid_o(resp_valid_o),
    .resp_data_o(resp_data_o), .resp_error_o(resp_error_o),
    .pe_valid_o(pe_valid), .pe_id_o(pe_id), .pe_op_o(pe_op), .pe_vfu_o(pe_vfu),
    .pe_vl_o(pe_vl), .pe_scalar_o(pe_scalar), .pe_vm_o(pe_vm),
    .pe_hazard_o(pe_hazard), .running_o(running),
    .pe_ready_i(pe_ready), .pe_done_i(pe_done),
    // Scalar answers come from lane 0 only
    .scalar_valid_i(pe_scalar_valid[0]), .scalar_data_i(pe_scalar_data[0]),
    .addr_ack_i(pe_addr_ack[LSU_IDX]), .addr_error_i(pe_addr_error[LSU_IDX])
  );

  for (genvar p = 0; p < NR_PES; p++) begin : g_pe
    // Lanes first, then the load/store unit and the mask unit
    localparam vfu_e UNIT = (p < NR_LANES) ? VFU_ALU :
                            ((p == LSU_IDX) ? VFU_LSU : VFU_MASK);
    vec_pe #(.UNIT(UNIT)) i_pe (
      .clk_i(clk_i), .rst_ni(rst_ni),
      .pe_valid_i(pe_valid), .pe_id_i(pe_id), .pe_op_i(pe_op), .pe_vfu_i(pe_vfu),
      .pe_vl_i(pe_vl), .pe_scalar_i(pe_scalar), .pe_vm_i(pe_vm),
      .pe_hazard_i(pe_hazard), .running_i(running),
      .ready_o(pe_ready[p]), .done_o(pe_done[p]),
      .scalar_valid_o(pe_scalar_valid[p]), .scalar_data_o(pe_scalar_data[p]),
      .addr_ack_o(pe_addr_ack[p]), .addr_error_o(pe_addr_error[p])
    );
  end

  // Any PE finishing an id shows on done_o
  always_comb begin
    done_o = '0;
    for (int p = 0; p < NR_PES; p++) begin
      done_o |= pe_done[p];
    end
  end

endmodule

// File: verification/tb_vec_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model for the vector subsystem testbench:
// ids, register lists, hazards and responses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Ids in flight, the hazard ids each one still waits for
logic [NR_VINSN-1:0] run_set;
logic [NR_VINSN-1:0] pending [NR_VINSN];
vec_op_e             run_op  [NR_VINSN];
// Last reader and last writer of each register
logic                rd_valid [NR_VREGS];
vid_t                rd_vid   [NR_VREGS];
logic                wr_valid [NR_VREGS];
vid_t                wr_vid   [NR_VREGS];
// Expected responses as {is_reduction, error, data}
logic [ELEN_W+1:0]   exp_q [$];

task automatic clear_model();
  run_set = '0;
  exp_q.delete();
  for (int i = 0; i < NR_VINSN; i++) begin
    pending[i] = '0;
    run_op[i]  = VADD;
  end
  for (int v = 0; v < NR_VREGS; v++) begin
    rd_valid[v] = 1'b0;
    wr_valid[v] = 1'b0;
    rd_vid[v]   = '0;
    wr_vid[v]   = '0;
  end
endtask

// Lowest id not in flight, -1 when all are taken
function automatic int lowest_free(logic [NR_VINSN-1:0] set);
  for (int i = 0; i < NR_VINSN; i++) begin
    if (!set[i])
      return i;
  end
  return -1;
endfunction

// Takes the request now on the dispatcher port
task automatic accept_insn();
  int                  id;
  logic [NR_VINSN-1:0] haz;
  logic                mask_busy;
  logic                store_busy;
  id         = lowest_free(run_set);
  mask_busy  = 1'b0;
  store_busy = 1'b0;
  for (int i = 0; i < NR_VINSN; i++) begin
    if (run_set[i] && (run_op[i] == VMAND))
      mask_busy = 1'b1;
    if (run_set[i] && (run_op[i] == VSE))
      store_busy = 1'b1;
  end
  assert (id >= 0) else begin
    errors++;
    $display("Request accepted while all %0d ids were in use", NR_VINSN);
  end
  assert (!((req_op_i == VSE) && mask_busy) && !((req_op_i == VMAND) && store_busy)) else begin
    errors++;
    $display("Store and mask instruction in flight together, new op %s", req_op_i.name());
  end
  if (id >= 0) begin
    haz = '0;
    // RAW on the sources and on v0 when masked
    if (req_use_vs1_i && wr_valid[req_vs1_i])
      haz[wr_vid[req_vs1_i]] = 1'b1;
    if (req_use_vs2_i && wr_valid[req_vs2_i])
      haz[wr_vid[req_vs2_i]] = 1'b1;
    if (!req_vm_i && wr_valid[VMASK_REG])
      haz[wr_vid[VMASK_REG]] = 1'b1;
    // WAR and WAW on the destination
    if (req_use_vd_i && rd_valid[req_vd_i])
      haz[rd_vid[req_vd_i]] = 1'b1;
    if (req_use_vd_i && wr_valid[req_vd_i])
      haz[wr_vid[req_vd_i]] = 1'b1;
    // New accesses go in after the lookup
    if (req_use_vd_i) begin
      wr_valid[req_vd_i] = 1'b1;
      wr_vid[req_vd_i]   = vid_t'(id);
    end
    if (req_use_vs1_i) begin
      rd_valid[req_vs1_i] = 1'b1;
      rd_vid[req_vs1_i]   = vid_t'(id);
    end
    if (req_use_vs2_i) begin
      rd_valid[req_vs2_i] = 1'b1;
      rd_vid[req_vs2_i]   = vid_t'(id);
    end
    if (!req_vm_i) begin
      rd_valid[VMASK_REG] = 1'b1;
      rd_vid[VMASK_REG]   = vid_t'(id);
    end
    run_set[id] = 1'b1;
    pending[id] = haz;
    run_op[id]  = req_op_i;
    // Reduction result is the scalar plus vl, misaligned base flags an error
    if (req_op_i == VREDSUM)
      exp_q.push_back({1'b1, 1'b0, req_scalar_i + ELEN_W'(req_vl_i)});
    else if (req_op_i inside {VLE, VSE})
      exp_q.push_back({1'b0, |req_scalar_i[1:0], ELEN_W'(0)});
  end
endtask

// Done pulses retire ids and release the ids waiting on them
task automatic retire_ids(logic [NR_VINSN-1:0] done);
  assert ((done & ~run_set) == '0) else begin
    errors++;
    $display("ERR done_o got 0x%h with running ids 0x%h", done, run_set);
  end
  for (int i = 0; i < NR_VINSN; i++) begin
    if (done[i] && run_set[i]) begin
      assert (pending[i] == '0) else begin
        errors++;
        $display("Id %0d finished before its hazard ids 0x%h", i, pending[i]);
      end
    end
  end
  for (int i = 0; i < NR_VINSN; i++) begin
    if (done[i]) begin
      run_set[i] = 1'b0;
      for (int j = 0; j < NR_VINSN; j++) begin
        pending[j][i] = 1'b0;
      end
      for (int v = 0; v < NR_VREGS; v++) begin
        if (rd_vid[v] == vid_t'(i))
          rd_valid[v] = 1'b0;
        if (wr_vid[v] == vid_t'(i))
          wr_valid[v] = 1'b0;
      end
    end
  end
endtask

// File: verification/tb_vec_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the vector subsystem: random
// instructions checked against a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_vec_top;

  import vec_pkg::*;

  localparam int SEED    = 32'h159b;
  localparam int TIMEOUT = 2000;
  localparam int N_INSN  = 200;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic                req_valid_i;
  vec_op_e             req_op_i;
  vreg_t               req_vs1_i, req_vs2_i, req_vd_i;
  logic                req_use_vs1_i, req_use_vs2_i, req_use_vd_i;
  logic                req_vm_i;
  logic [VL_W-1:0]     req_vl_i;
  logic [ELEN_W-1:0]   req_scalar_i;
  logic                req_ready_o;
  logic                resp_valid_o;
  logic [ELEN_W-1:0]   resp_data_o;
  logic                resp_error_o;
  logic [NR_VINSN-1:0] done_o;

  integer seed;
  int     errors, timeouts, sent, responses;
  logic   timed_out;

  `include "tb_vec_model.svh"

  vec_top DUT (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_valid_i(req_valid_i), .req_op_i(req_op_i),
    .req_vs1_i(req_vs1_i), .req_use_vs1_i(req_use_vs1_i),
    .req_vs2_i(req_vs2_i), .req_use_vs2_i(req_use_vs2_i),
    .req_vd_i(req_vd_i), .req_use_vd_i(req_use_vd_i), .req_vm_i(req_vm_i),
    .req_vl_i(req_vl_i), .req_scalar_i(req_scalar_i), .req_ready_o(req_ready_o),
    .resp_valid_o(resp_valid_o), .resp_data_o(resp_data_o),
    .resp_error_o(resp_error_o), .done_o(done_o)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  // Drives one random instruction and waits for the handshake
  task automatic send_insn(int n);
    int   cycles;
    logic accepted;
    @(negedge clk_i);
    req_op_i      = vec_op_e'($unsigned($random(seed)) % 6);
    // Four registers only, so hazards show up often
    req_vs1_i     = vreg_t'($unsigned($random(seed)) % 4);
    req_vs2_i     = vreg_t'($unsigned($random(seed)) % 4);
    req_vd_i      = vreg_t'($unsigned($random(seed)) % 4);
    req_use_vs1_i = (req_op_i != VLE);
    req_use_vs2_i = !(req_op_i inside {VLE, VSE});
    req_use_vd_i  = !(req_op_i inside {VREDSUM, VSE});
    // Only the mask op runs masked, each id then finishes on one unit
    req_vm_i      = (req_op_i == VMAND) ? (($random(seed) % 2) == 0) : 1'b1;
    req_vl_i      = VL_W'($unsigned($random(seed)) % 16);
    req_scalar_i  = $random(seed);
    req_valid_i   = 1'b1;
    accepted = 1'b0;
    cycles   = 0;
    // Ready settles after the negedge drive, the transfer is at the next posedge
    while (!accepted && (cycles < TIMEOUT)) begin
      #1;
      if (req_ready_o) begin
        accepted = 1'b1;
      end else begin
        @(negedge clk_i);
        cycles++;
      end
    end
    assert (accepted) else begin
      timeouts++;
      timed_out = 1'b1;
      $display("Timeout: request %0d with op %s was never accepted", n, req_op_i.name());
    end
    if (accepted) begin
      accept_insn();
      sent++;
    end
  endtask

  task automatic check_response(logic [ELEN_W-1:0] data, logic err);
    logic [ELEN_W+1:0] exp;
    responses++;
    assert (exp_q.size() > 0) else begin
      errors++;
      $display("Response strobe with no load, store or reduction waiting");
    end
    if (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      if (exp[ELEN_W+1]) begin
        assert (data == exp[ELEN_W-1:0]) else begin
          errors++;
          $display("ERR resp_data_o got 0x%h expected 0x%h", data, exp[ELEN_W-1:0]);
        end
      end else begin
        assert (err == exp[ELEN_W]) else begin
          errors++;
          $display("ERR resp_error_o got 0x%h expected 0x%h", err, exp[ELEN_W]);
        end
      end
    end
  endtask

  // Every issued id has to retire and every response has to arrive
  task automatic drain();
    int cycles;
    cycles = 0;
    while (((run_set != '0) || (exp_q.size() != 0)) && (cycles < TIMEOUT)) begin
      @(negedge clk_i);
      #3;
      cycles++;
    end
    assert ((run_set == '0) && (exp_q.size() == 0)) else begin
      timeouts++;
      $display("Timeout: ids 0x%h still running, %0d responses missing",
               run_set, exp_q.size());
    end
  endtask

  task automatic finish_run();
    $display("Summary: sent %0d responses %0d errors %0d timeouts %0d",
             sent, responses, errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  // Outputs sampled at the negedge, model updated after the driver
  initial begin : monitor
    logic [NR_VINSN-1:0] done_s;
    logic                rv;
    logic [ELEN_W-1:0]   rd;
    logic                re;
    forever begin
      @(negedge clk_i);
      done_s = done_o;
      rv     = resp_valid_o;
      rd     = resp_data_o;
      re     = resp_error_o;
      #2;
      if (rst_ni) begin
        if (rv)
          check_response(rd, re);
        if (done_s != '0)
          retire_ids(done_s);
      end
    end
  end

  initial begin
    int gap;
    seed      = SEED;
    errors    = 0;
    timeouts  = 0;
    sent      = 0;
    responses = 0;
    timed_out = 1'b0;
    clear_model();
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    req_op_i      = VADD;
    req_vs1_i     = '0;
    req_vs2_i     = '0;
    req_vd_i      = '0;
    req_use_vs1_i = 1'b0;
    req_use_vs2_i = 1'b0;
    req_use_vd_i  = 1'b0;
    req_vm_i      = 1'b1;
    req_vl_i      = '0;
    req_scalar_i  = '0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    // Idle state after reset
    @(negedge clk_i);
    #1;
    assert (req_ready_o === 1'b1) else begin
      errors++;
      $display("ERR req_ready_o got 0x%h expected 0x1", req_ready_o);
    end
    assert (resp_valid_o === 1'b0) else begin
      errors++;
      $display("ERR resp_valid_o got 0x%h expected 0x0", resp_valid_o);
    end
    assert (done_o === '0) else begin
      errors++;
      $display("ERR done_o got 0x%h expected 0x0", done_o);
    end

    for (int n = 0; (n < N_INSN) && !timed_out; n++) begin
      send_insn(n);
      gap = $unsigned($random(seed)) % 3;
      // Some requests go back to back, others after idle cycles
      if (!timed_out && (gap != 0)) begin
        @(negedge clk_i);
        req_valid_i = 1'b0;
        repeat (gap - 1) @(negedge clk_i);
      end
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    if (!timed_out)
      drain();
    finish_run();
  end

endmodule

// File: vec.f
+incdir+verification
verilog/vec_pkg.sv
verilog/vec_free_id.sv
verilog/vec_sequencer.sv
verilog/vec_insn_queue.sv
verilog/vec_pe.sv
verilog/vec_top.sv
verification/tb_vec_top.sv

// File: run.sh
#!/bin/sh
# Builds the vector subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f vec.f \
    --top-module tb_vec_top -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_vec_top)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
